// ==== verilog/slide_macros.svh ====
// Sizes shared by the slide unit RTL and its testbench
// Include wherever a lane count, a depth or a field width is needed
`ifndef SLIDE_MACROS_SVH
`define SLIDE_MACROS_SVH

// Datapath geometry
`define SLIDE_NR_LANES     4
`define SLIDE_LANE_BYTES   8
// One full word spans every lane
`define SLIDE_WORD_BYTES   (`SLIDE_NR_LANES * `SLIDE_LANE_BYTES)
// Full words per vector register, 128 bytes in all
`define SLIDE_REG_WORDS    4

// Queue depths
`define SLIDE_INSN_DEPTH   4
`define SLIDE_RESULT_DEPTH 2

// Field widths
`define SLIDE_ID_W         3
`define SLIDE_ADDR_W       8

`endif

// ==== verilog/slide_pkg.sv ====
// Types and helpers of the slide unit
// Ports name these by scope, module bodies import the package
`include "slide_macros.svh"

package slide_pkg;

  typedef enum logic {
    SLIDE_UP,
    SLIDE_DOWN
  } slide_op_e;

  // Element width code, log2 of the element size in bytes
  typedef enum logic [1:0] {
    SEW8,
    SEW16,
    SEW32,
    SEW64
  } sew_e;

  typedef logic [`SLIDE_LANE_BYTES*8-1:0] lane_word_t;
  typedef logic [`SLIDE_LANE_BYTES-1:0]   lane_strb_t;
  // Byte count over a whole register, 0 up to 128
  typedef logic [7:0]                     byte_cnt_t;
  typedef logic [`SLIDE_ID_W-1:0]         insn_id_t;
  typedef logic [4:0]                     vreg_t;

  typedef struct packed {
    insn_id_t  id;
    slide_op_e op;
    sew_e      sew;
    byte_cnt_t vl;      // bytes once queued
    byte_cnt_t offset;  // bytes once queued
    vreg_t     vd;
  } slide_insn_t;

  // Element count scaled to bytes
  function automatic byte_cnt_t slide_to_bytes(byte_cnt_t elems, sew_e sew);
    return byte_cnt_t'(elems << int'(sew));
  endfunction

  // Result words written by a queued instruction, vl and offset in bytes
  // Slide-up skips the words wholly below the offset
  function automatic int unsigned slide_beat_count(slide_insn_t insn);
    int unsigned first_word;
    int unsigned end_word;
    first_word = (insn.op == SLIDE_UP) ? int'(insn.offset) / `SLIDE_WORD_BYTES : 0;
    end_word   = (int'(insn.vl) + `SLIDE_WORD_BYTES - 1) / `SLIDE_WORD_BYTES;
    return end_word - first_word;
  endfunction

endpackage

// ==== verilog/slide_insn_queue.sv ====
`timescale 1ns/100ps
// Circular queue of accepted slide instructions
// The issue head is registered for the engine, the commit head is read
// straight from storage. An entry frees only when its instruction commits
`include "slide_macros.svh"

module slide_insn_queue (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   insn_valid_i,
  input  slide_pkg::insn_id_t    insn_id_i,
  input  slide_pkg::slide_op_e   insn_op_i,
  input  slide_pkg::sew_e        insn_sew_i,
  input  slide_pkg::byte_cnt_t   insn_vl_i,
  input  slide_pkg::byte_cnt_t   insn_offset_i,
  input  slide_pkg::vreg_t       insn_vd_i,
  output logic                   insn_ready_o,
  output slide_pkg::slide_insn_t issue_insn_o,
  output logic                   issue_valid_o,
  input  logic                   issue_pop_i,
  output slide_pkg::slide_insn_t commit_insn_o,
  output logic                   commit_valid_o,
  input  logic                   commit_pop_i
);
  import slide_pkg::*;

  localparam int unsigned DEPTH = `SLIDE_INSN_DEPTH;
  localparam int unsigned PNT_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = PNT_W + 1;

  slide_insn_t      mem_q [DEPTH];
  slide_insn_t      new_insn;
  logic [PNT_W-1:0] accept_pnt_q, issue_pnt_q, commit_pnt_q;
  logic [PNT_W-1:0] issue_pnt_d;
  // Pending issue, and everything not yet committed
  logic [CNT_W-1:0] issue_cnt_q, commit_cnt_q;
  logic [CNT_W-1:0] issue_cnt_d;
  logic             accept;

  function automatic logic [PNT_W-1:0] next_pnt(logic [PNT_W-1:0] pnt);
    return (pnt == PNT_W'(DEPTH - 1)) ? '0 : pnt + 1'b1;
  endfunction

  // Full means every entry waits for commit
  assign insn_ready_o = (commit_cnt_q != CNT_W'(DEPTH));
  assign accept       = insn_valid_i && insn_ready_o;

  // Offset and vl are held in bytes from here on
  always_comb begin
    new_insn        = '0;
    new_insn.id     = insn_id_i;
    new_insn.op     = insn_op_i;
    new_insn.sew    = insn_sew_i;
    new_insn.vl     = slide_to_bytes(insn_vl_i, insn_sew_i);
    new_insn.offset = slide_to_bytes(insn_offset_i, insn_sew_i);
    new_insn.vd     = insn_vd_i;
  end

  assign issue_pnt_d = issue_pop_i ? next_pnt(issue_pnt_q) : issue_pnt_q;
  assign issue_cnt_d = issue_cnt_q + CNT_W'(accept) - CNT_W'(issue_pop_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q  <= '0;
      issue_pnt_q   <= '0;
      commit_pnt_q  <= '0;
      issue_cnt_q   <= '0;
      commit_cnt_q  <= '0;
      issue_valid_o <= 1'b0;
    end else begin
      if (accept) begin
        accept_pnt_q <= next_pnt(accept_pnt_q);
      end
      if (commit_pop_i) begin
        commit_pnt_q <= next_pnt(commit_pnt_q);
      end
      issue_pnt_q   <= issue_pnt_d;
      issue_cnt_q   <= issue_cnt_d;
      commit_cnt_q  <= commit_cnt_q + CNT_W'(accept) - CNT_W'(commit_pop_i);
      issue_valid_o <= (issue_cnt_d != '0);
    end
  end

  // Storage, plus the issue head one cycle after accept or pop
  always_ff @(posedge clk_i) begin
    if (accept) begin
      mem_q[accept_pnt_q] <= new_insn;
    end
    // Empty issue side, the new instruction goes straight to the head
    if (accept && accept_pnt_q == issue_pnt_d) begin
      issue_insn_o <= new_insn;
    end else begin
      issue_insn_o <= mem_q[issue_pnt_d];
    end
  end

  assign commit_insn_o  = mem_q[commit_pnt_q];
  assign commit_valid_o = (commit_cnt_q != '0);

endmodule

// ==== verilog/slide_engine.sv ====
`timescale 1ns/100ps
// Slide engine, moves operand bytes to their slid position
// Builds one full result word at a time and broadcasts it to all lane buffers.
// Stalls while any lane buffer is full
`include "slide_macros.svh"

module slide_engine (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  slide_pkg::slide_insn_t                      issue_insn_i,
  input  logic                                        issue_valid_i,
  output logic                                        issue_pop_o,
  input  slide_pkg::lane_word_t [`SLIDE_NR_LANES-1:0] operand_i,
  input  logic                                        operand_valid_i,
  output logic                                        operand_ready_o,
  input  logic [`SLIDE_NR_LANES-1:0]                  buf_full_i,
  output logic                                        push_o,
  output logic [`SLIDE_ADDR_W-1:0]                    push_addr_o,
  output slide_pkg::lane_word_t [`SLIDE_NR_LANES-1:0] push_wdata_o,
  output slide_pkg::lane_strb_t [`SLIDE_NR_LANES-1:0] push_be_o
);
  import slide_pkg::*;

  localparam int unsigned WORD_BYTES = `SLIDE_WORD_BYTES;
  localparam int unsigned PNT_W      = $clog2(WORD_BYTES) + 1;
  localparam int unsigned VRF_W      = $clog2(`SLIDE_REG_WORDS);
  localparam int unsigned ADDR_W     = `SLIDE_ADDR_W;

  typedef enum logic {
    IDLE,
    RUN
  } state_e;

  state_e                  state_q, state_d;
  // Byte pointers into the operand word and the result word
  logic [PNT_W-1:0]        in_pnt_q, in_pnt_d;
  logic [PNT_W-1:0]        out_pnt_q, out_pnt_d;
  byte_cnt_t               remaining_q, remaining_d;
  logic [VRF_W-1:0]        vrf_pnt_q, vrf_pnt_d;
  // Result word under construction, may span two operand words
  logic [WORD_BYTES*8-1:0] word_q, word_d;
  logic [WORD_BYTES-1:0]   be_q, be_d;
  logic [WORD_BYTES*8-1:0] operand_flat;
  logic [PNT_W-1:0]        in_rem, out_rem, step;
  logic                    last;

  // Byte b of a word sits in lane b / LANE_BYTES
  assign operand_flat = operand_i;
  assign push_wdata_o = word_d;
  assign push_be_o    = be_d;
  assign push_addr_o  = ADDR_W'(issue_insn_i.vd) * ADDR_W'(`SLIDE_REG_WORDS)
                      + ADDR_W'(vrf_pnt_q);

  //////////////////////////////////////////////////////////////////////
  // Slide FSM
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    in_pnt_d        = in_pnt_q;
    out_pnt_d       = out_pnt_q;
    remaining_d     = remaining_q;
    vrf_pnt_d       = vrf_pnt_q;
    word_d          = word_q;
    be_d            = be_q;
    issue_pop_o     = 1'b0;
    operand_ready_o = 1'b0;
    push_o          = 1'b0;

    // Copy as far as the nearer word boundary
    in_rem  = PNT_W'(WORD_BYTES) - in_pnt_q;
    out_rem = PNT_W'(WORD_BYTES) - out_pnt_q;
    step    = (in_rem < out_rem) ? in_rem : out_rem;
    last    = (remaining_q <= byte_cnt_t'(step));
    // Final step trimmed to the bytes still owed
    if (last) begin
      step = PNT_W'(remaining_q);
    end

    unique case (state_q)
      IDLE: begin
        if (issue_valid_i) begin
          state_d = RUN;
          if (issue_insn_i.op == SLIDE_UP) begin
            // Source from byte 0, destination from the offset up to vl
            in_pnt_d    = '0;
            out_pnt_d   = PNT_W'(issue_insn_i.offset % WORD_BYTES);
            remaining_d = issue_insn_i.vl - issue_insn_i.offset;
            vrf_pnt_d   = VRF_W'(issue_insn_i.offset / WORD_BYTES);
          end else begin
            // Source from the offset, destination from byte 0
            in_pnt_d    = PNT_W'(issue_insn_i.offset % WORD_BYTES);
            out_pnt_d   = '0;
            remaining_d = issue_insn_i.vl;
            vrf_pnt_d   = '0;
          end
        end
      end

      RUN: begin
        // One step per cycle, operand in hand and room in every lane
        if (operand_valid_i && !(|buf_full_i)) begin
          for (int b = 0; b < WORD_BYTES; b++) begin
            if (b < int'(step)) begin
              word_d[8*(int'(out_pnt_q) + b) +: 8] =
                operand_flat[8*(int'(in_pnt_q) + b) +: 8];
              be_d[int'(out_pnt_q) + b] = 1'b1;
            end
          end
          in_pnt_d    = in_pnt_q + step;
          out_pnt_d   = out_pnt_q + step;
          remaining_d = remaining_q - byte_cnt_t'(step);

          // Operand used up, or nothing more is needed from it
          if (in_pnt_d == PNT_W'(WORD_BYTES) || last) begin
            in_pnt_d        = '0;
            operand_ready_o = 1'b1;
          end
          // Result word full, or the instruction ends inside it
          if (out_pnt_d == PNT_W'(WORD_BYTES) || last) begin
            out_pnt_d = '0;
            vrf_pnt_d = vrf_pnt_q + 1'b1;
            push_o    = 1'b1;
          end
          if (last) begin
            state_d     = IDLE;
            issue_pop_o = 1'b1;
          end
        end
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= IDLE;
      in_pnt_q    <= '0;
      out_pnt_q   <= '0;
      remaining_q <= '0;
      vrf_pnt_q   <= '0;
      be_q        <= '0;
    end else begin
      state_q     <= state_d;
      in_pnt_q    <= in_pnt_d;
      out_pnt_q   <= out_pnt_d;
      remaining_q <= remaining_d;
      vrf_pnt_q   <= vrf_pnt_d;
      // Next word starts with no bytes enabled
      be_q        <= push_o ? '0 : be_d;
    end
  end

  always_ff @(posedge clk_i) begin
    word_q <= word_d;
  end

endmodule

// ==== verilog/lane_result_buf.sv ====
`timescale 1ns/100ps
// Result buffer of one lane
// Holds words pushed by the engine until the lane register file grants them
`include "slide_macros.svh"

module lane_result_buf (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     push_i,
  input  logic [`SLIDE_ADDR_W-1:0] addr_i,
  input  slide_pkg::lane_word_t    wdata_i,
  input  slide_pkg::lane_strb_t    be_i,
  output logic                     full_o,
  output logic                     pop_o,
  output logic                     result_req_o,
  output logic [`SLIDE_ADDR_W-1:0] result_addr_o,
  output slide_pkg::lane_word_t    result_wdata_o,
  output slide_pkg::lane_strb_t    result_be_o,
  input  logic                     result_gnt_i
);
  import slide_pkg::*;

  localparam int unsigned DEPTH = `SLIDE_RESULT_DEPTH;
  localparam int unsigned PNT_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [`SLIDE_ADDR_W-1:0] addr_q  [DEPTH];
  lane_word_t               wdata_q [DEPTH];
  lane_strb_t               be_q    [DEPTH];
  logic [PNT_W-1:0]         wr_pnt_q, rd_pnt_q;
  logic [CNT_W-1:0]         cnt_q;

  assign full_o = (cnt_q == CNT_W'(DEPTH));

  // Head entry drives the lane request
  assign result_req_o   = (cnt_q != '0);
  assign result_addr_o  = addr_q[rd_pnt_q];
  assign result_wdata_o = wdata_q[rd_pnt_q];
  assign result_be_o    = be_q[rd_pnt_q];
  // Head leaves in the cycle of its grant
  assign pop_o          = result_req_o && result_gnt_i;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      addr_q[wr_pnt_q]  <= addr_i;
      wdata_q[wr_pnt_q] <= wdata_i;
      be_q[wr_pnt_q]    <= be_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_pnt_q <= (wr_pnt_q == PNT_W'(DEPTH - 1)) ? '0 : wr_pnt_q + 1'b1;
      end
      if (pop_o) begin
        rd_pnt_q <= (rd_pnt_q == PNT_W'(DEPTH - 1)) ? '0 : rd_pnt_q + 1'b1;
      end
      cnt_q <= cnt_q + CNT_W'(push_i) - CNT_W'(pop_o);
    end
  end

endmodule

// ==== verilog/slide_commit.sv ====
`timescale 1ns/100ps
// Commit tracker of the slide unit
// Counts granted words per lane and signals done once every lane has
// written all words of the oldest instruction
`include "slide_macros.svh"

module slide_commit (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  slide_pkg::slide_insn_t     commit_insn_i,
  input  logic                       commit_valid_i,
  output logic                       commit_pop_o,
  input  logic [`SLIDE_NR_LANES-1:0] lane_pop_i,
  output logic                       done_o,
  output slide_pkg::insn_id_t        done_id_o
);
  import slide_pkg::*;

  // A fast lane may lead the slowest by up to a full result buffer
  localparam int unsigned CNT_W = $clog2(`SLIDE_REG_WORDS + `SLIDE_RESULT_DEPTH + 1);

  logic [CNT_W-1:0] pop_cnt_q [`SLIDE_NR_LANES];
  logic [CNT_W-1:0] beats;
  logic             all_done;

  assign beats = CNT_W'(slide_beat_count(commit_insn_i));

  // Head is complete when every lane has popped all its words
  always_comb begin
    all_done = commit_valid_i;
    for (int l = 0; l < `SLIDE_NR_LANES; l++) begin
      if (pop_cnt_q[l] < beats) begin
        all_done = 1'b0;
      end
    end
  end

  assign done_o       = all_done;
  assign done_id_o    = commit_insn_i.id;
  assign commit_pop_o = all_done;

  // Words beyond the head already belong to the next instruction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int l = 0; l < `SLIDE_NR_LANES; l++) begin
        pop_cnt_q[l] <= '0;
      end
    end else begin
      for (int l = 0; l < `SLIDE_NR_LANES; l++) begin
        pop_cnt_q[l] <= pop_cnt_q[l] - (all_done ? beats : '0) + CNT_W'(lane_pop_i[l]);
      end
    end
  end

endmodule

// ==== verilog/slide_unit.sv ====
`timescale 1ns/100ps
// Slide unit top level
// Instruction queue, slide engine, one result buffer per lane and the
// commit tracker, connected by wires only
`include "slide_macros.svh"

module slide_unit (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  // Instruction input
  input  logic                                        insn_valid_i,
  input  slide_pkg::insn_id_t                         insn_id_i,
  input  slide_pkg::slide_op_e                        insn_op_i,
  input  slide_pkg::sew_e                             insn_sew_i,
  input  slide_pkg::byte_cnt_t                        insn_vl_i,
  input  slide_pkg::byte_cnt_t                        insn_offset_i,
  input  slide_pkg::vreg_t                            insn_vd_i,
  output logic                                        insn_ready_o,
  // Source words, all lanes at once
  input  slide_pkg::lane_word_t [`SLIDE_NR_LANES-1:0] operand_i,
  input  logic                                        operand_valid_i,
  output logic                                        operand_ready_o,
  // Lane register file writes
  output logic [`SLIDE_NR_LANES-1:0]                  result_req_o,
  output logic [`SLIDE_NR_LANES-1:0][`SLIDE_ADDR_W-1:0] result_addr_o,
  output slide_pkg::lane_word_t [`SLIDE_NR_LANES-1:0] result_wdata_o,
  output slide_pkg::lane_strb_t [`SLIDE_NR_LANES-1:0] result_be_o,
  input  logic [`SLIDE_NR_LANES-1:0]                  result_gnt_i,
  // End of instruction
  output logic                                        done_o,
  output slide_pkg::insn_id_t                         done_id_o
);
  import slide_pkg::*;

  slide_insn_t                             issue_insn, commit_insn;
  logic                                    issue_valid, issue_pop;
  logic                                    commit_valid, commit_pop;
  logic                                    push;
  logic [`SLIDE_ADDR_W-1:0]                push_addr;
  lane_word_t [`SLIDE_NR_LANES-1:0]        push_wdata;
  lane_strb_t [`SLIDE_NR_LANES-1:0]        push_be;
  logic [`SLIDE_NR_LANES-1:0]              buf_full, lane_pop;

  slide_insn_queue i_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .insn_valid_i   (insn_valid_i),
    .insn_id_i      (insn_id_i),
    .insn_op_i      (insn_op_i),
    .insn_sew_i     (insn_sew_i),
    .insn_vl_i      (insn_vl_i),
    .insn_offset_i  (insn_offset_i),
    .insn_vd_i      (insn_vd_i),
    .insn_ready_o   (insn_ready_o),
    .issue_insn_o   (issue_insn),
    .issue_valid_o  (issue_valid),
    .issue_pop_i    (issue_pop),
    .commit_insn_o  (commit_insn),
    .commit_valid_o (commit_valid),
    .commit_pop_i   (commit_pop)
  );

  slide_engine i_engine (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue_insn_i    (issue_insn),
    .issue_valid_i   (issue_valid),
    .issue_pop_o     (issue_pop),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .buf_full_i      (buf_full),
    .push_o          (push),
    .push_addr_o     (push_addr),
    .push_wdata_o    (push_wdata),
    .push_be_o       (push_be)
  );

  // Every lane takes each pushed word, its own slice of it
  for (genvar l = 0; l < `SLIDE_NR_LANES; l++) begin : gen_lane
    lane_result_buf i_buf (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .push_i         (push),
      .addr_i         (push_addr),
      .wdata_i        (push_wdata[l]),
      .be_i           (push_be[l]),
      .full_o         (buf_full[l]),
      .pop_o          (lane_pop[l]),
      .result_req_o   (result_req_o[l]),
      .result_addr_o  (result_addr_o[l]),
      .result_wdata_o (result_wdata_o[l]),
      .result_be_o    (result_be_o[l]),
      .result_gnt_i   (result_gnt_i[l])
    );
  end

  slide_commit i_commit (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .commit_insn_i  (commit_insn),
    .commit_valid_i (commit_valid),
    .commit_pop_o   (commit_pop),
    .lane_pop_i     (lane_pop),
    .done_o         (done_o),
    .done_id_o      (done_id_o)
  );

endmodule

// ==== verif/slide_unit_props.sv ====
`timescale 1ns/100ps
// Handshake properties of the slide unit
// Bound to every slide_unit instance
`include "slide_macros.svh"

module slide_unit_props (
  input logic                                         clk_i,
  input logic                                         rst_ni,
  input logic                                         insn_ready_o,
  input logic                                         operand_ready_o,
  input logic                                         done_o,
  input logic [`SLIDE_NR_LANES-1:0]                   result_req_o,
  input logic [`SLIDE_NR_LANES-1:0]                   result_gnt_i,
  input logic [`SLIDE_NR_LANES-1:0][`SLIDE_ADDR_W-1:0] result_addr_o,
  input slide_pkg::lane_word_t [`SLIDE_NR_LANES-1:0]  result_wdata_o,
  input slide_pkg::lane_strb_t [`SLIDE_NR_LANES-1:0]  result_be_o
);

  // Quiet outputs while in reset
  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |-> insn_ready_o && !operand_ready_o && result_req_o == '0 && !done_o)
    else $error("Outputs active during reset");

  // Done comes the cycle after a lane write completes an instruction
  done_after_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |-> $past(|(result_req_o & result_gnt_i)))
    else $error("Done without a lane write in the cycle before");

  // Request holds with a stable payload until granted
  for (genvar l = 0; l < `SLIDE_NR_LANES; l++) begin : gen_lane_props
    req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o[l] && !result_gnt_i[l] |=> result_req_o[l]
        && $stable(result_addr_o[l]) && $stable(result_wdata_o[l])
        && $stable(result_be_o[l]))
      else $error("Lane %0d request dropped or changed before grant", l);
  end

endmodule

bind slide_unit slide_unit_props i_props (.*);

// ==== verif/tb_slide_unit.sv ====
`timescale 1ns/100ps
// Self-checking testbench of the slide unit
// Reads instructions, source words and grant modes from the data file,
// predicts every lane write and done strobe, and checks them
`include "slide_macros.svh"

module tb_slide_unit;
  import slide_pkg::*;

  localparam int NL = `SLIDE_NR_LANES;
  localparam int WB = `SLIDE_WORD_BYTES;

  typedef struct packed {
    logic [2:0]  id;
    logic [7:0]  addr;
    logic [63:0] data;
    logic [7:0]  be;
  } exp_t;

  logic                    clk_i = 1'b0;
  logic                    rst_ni;
  logic                    insn_valid_i;
  insn_id_t                insn_id_i;
  slide_op_e               insn_op_i;
  sew_e                    insn_sew_i;
  byte_cnt_t               insn_vl_i, insn_offset_i;
  vreg_t                   insn_vd_i;
  logic                    insn_ready_o;
  lane_word_t [NL-1:0]     operand_i;
  logic                    operand_valid_i, operand_ready_o;
  logic [NL-1:0]           result_req_o, result_gnt_i;
  logic [NL-1:0][7:0]      result_addr_o;
  lane_word_t [NL-1:0]     result_wdata_o;
  lane_strb_t [NL-1:0]     result_be_o;
  logic                    done_o;
  insn_id_t                done_id_o;

  // Model state
  logic [7:0]    src [128];
  logic [255:0]  opnd_q [$];
  exp_t          exp_q [NL][$];
  logic [2:0]    done_q [$];
  logic [2:0]    next_id;
  int            gnt_mode;
  int            err_cnt, tmo_cnt;

  slide_unit UUT (.*);

  always #2 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////
  // Checking and run control
  ////////////////////////////////////////////////////////////////////

  task automatic check_value(string what, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("Closing: %0d mismatches, %0d timeouts", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  task automatic give_up(string what);
    tmo_cnt++;
    $display("Timed out at %0t while waiting for %s", $time, what);
    finish_run();
  endtask

  function automatic logic [63:0] byte_mask(logic [7:0] be);
    logic [63:0] m;
    for (int b = 0; b < 8; b++) begin
      m[8*b +: 8] = {8{be[b]}};
    end
    return m;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////

  // Expected writes and source words come straight from the slide rules
  task automatic send_insn(int op, int sew, int vl, int off, int vd);
    int   vl_b, off_b, first, last, j, src_lo, src_hi, n;
    exp_t e;
    logic [255:0] w;
    vl_b  = vl << sew;
    off_b = off << sew;
    first = (op == 0) ? off_b / WB : 0;
    last  = (vl_b - 1) / WB;
    @(negedge clk_i);
    insn_valid_i  = 1'b1;
    insn_id_i     = next_id;
    insn_op_i     = slide_op_e'(op);
    insn_sew_i    = sew_e'(sew);
    insn_vl_i     = byte_cnt_t'(vl);
    insn_offset_i = byte_cnt_t'(off);
    insn_vd_i     = vreg_t'(vd);
    n = 0;
    do begin
      @(posedge clk_i);
      n++;
      if (n > 500) give_up("instruction acceptance");
    end while (!insn_ready_o);
    for (int wi = first; wi <= last; wi++) begin
      for (int l = 0; l < NL; l++) begin
        e      = '0;
        e.id   = next_id;
        e.addr = 8'(vd * `SLIDE_REG_WORDS + wi);
        for (int b = 0; b < 8; b++) begin
          j = wi * WB + l * 8 + b;
          if (op == 0 && j >= off_b && j < vl_b) begin
            e.be[b] = 1'b1;
            e.data[8*b +: 8] = src[j - off_b];
          end else if (op == 1 && j < vl_b) begin
            e.be[b] = 1'b1;
            e.data[8*b +: 8] = src[j + off_b];
          end
        end
        exp_q[l].push_back(e);
      end
    end
    // Source words covering the bytes that are read
    src_lo = (op == 0) ? 0 : off_b / WB;
    src_hi = (op == 0) ? (vl_b - off_b - 1) / WB : (off_b + vl_b - 1) / WB;
    for (int wi = src_lo; wi <= src_hi; wi++) begin
      for (int k = 0; k < WB; k++) begin
        w[8*k +: 8] = src[wi * WB + k];
      end
      opnd_q.push_back(w);
    end
    done_q.push_back(next_id);
    next_id++;
    @(negedge clk_i);
    insn_valid_i = 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (done_q.size() != 0) begin
      @(posedge clk_i);
      n++;
      if (n > 4000) give_up("all instructions to finish");
    end
    for (int l = 0; l < NL; l++) begin
      if (exp_q[l].size() != 0) begin
        err_cnt++;
        $display("Lane %0d still owes %0d writes after drain", l, exp_q[l].size());
      end
    end
  endtask

  task automatic wait_queue_full();
    int n;
    n = 0;
    while (insn_ready_o) begin
      @(posedge clk_i);
      n++;
      if (n > 200) give_up("instruction ready to fall");
    end
  endtask

  // Operands and grants change on the falling edge
  always @(negedge clk_i) begin
    operand_valid_i <= (opnd_q.size() != 0);
    operand_i       <= (opnd_q.size() != 0) ? opnd_q[0] : '0;
    for (int l = 0; l < NL; l++) begin
      case (gnt_mode)
        0:       result_gnt_i[l] <= 1'b1;
        1:       result_gnt_i[l] <= ($urandom % 3) != 0;
        default: result_gnt_i[l] <= 1'b0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Response monitor
  ////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    exp_t        e;
    logic [63:0] m;
    if (rst_ni) begin
      if (operand_valid_i && operand_ready_o) begin
        void'(opnd_q.pop_front());
      end
      for (int l = 0; l < NL; l++) begin
        if (result_req_o[l] && result_gnt_i[l]) begin
          if (exp_q[l].size() == 0) begin
            err_cnt++;
            $display("Lane %0d wrote a word that no instruction produces", l);
          end else begin
            e = exp_q[l].pop_front();
            m = byte_mask(e.be);
            check_value("address", 64'(result_addr_o[l]), 64'(e.addr));
            check_value("byte enables", 64'(result_be_o[l]), 64'(e.be));
            check_value("data", result_wdata_o[l] & m, e.data & m);
          end
        end
      end
      if (done_o) begin
        if (done_q.size() == 0) begin
          err_cnt++;
          $display("Done strobe without an outstanding instruction");
        end else begin
          check_value("done id", 64'(done_id_o), 64'(done_q.pop_front()));
          for (int l = 0; l < NL; l++) begin
            if (exp_q[l].size() != 0 && exp_q[l][0].id == done_id_o) begin
              err_cnt++;
              $display("Done for id %0d before lane %0d finished", done_id_o, l);
            end
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////

  initial begin
    int           fd, idx, op, sew, vl, off, vd;
    string        line;
    logic [255:0] w;
    void'($urandom(75907));
    rst_ni          = 1'b0;
    insn_valid_i    = 1'b0;
    insn_id_i       = '0;
    insn_op_i       = SLIDE_UP;
    insn_sew_i      = SEW8;
    insn_vl_i       = '0;
    insn_offset_i   = '0;
    insn_vd_i       = '0;
    operand_i       = '0;
    operand_valid_i = 1'b0;
    result_gnt_i    = '0;
    gnt_mode        = 0;
    next_id         = '0;
    err_cnt         = 0;
    tmo_cnt         = 0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    fd = $fopen("verif/slide_testdata.txt", "r");
    if (fd == 0) begin
      tmo_cnt++;
      $display("Could not open the test data file");
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2) continue;
        case (line.getc(0))
          "W": begin
            void'($sscanf(line, "W %d %h", idx, w));
            for (int k = 0; k < WB; k++) begin
              src[idx * WB + k] = w[8*k +: 8];
            end
          end
          "I": begin
            void'($sscanf(line, "I %d %d %d %d %d", op, sew, vl, off, vd));
            send_insn(op, sew, vl, off, vd);
          end
          "G": void'($sscanf(line, "G %d", gnt_mode));
          "F": wait_queue_full();
          "D": wait_drain();
          default: ;
        endcase
      end
      $fclose(fd);
      wait_drain();
    end
    finish_run();
  end

endmodule

// ==== verilog.f ====
+incdir+verilog
verilog/slide_pkg.sv
verilog/slide_insn_queue.sv
verilog/slide_engine.sv
verilog/lane_result_buf.sv
verilog/slide_commit.sv
verilog/slide_unit.sv
verif/slide_unit_props.sv
verif/tb_slide_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the slide unit testbench with Verilator and run it.
# The run fails if the log holds the fail message.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f \
  --top-module tb_slide_unit \
  -o Vtb_slide_unit

./obj_dir/Vtb_slide_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
if ! grep -q "ALL TESTS PASSED" sim.log; then
  exit 1
fi
exit 0

// ==== verif/slide_testdata.txt ====
# W word hex : source register word, byte 0 rightmost
# I op sew vl offset vd : op 0 up 1 down, sew 0..3, vl and offset in elements
# G mode : 0 always grant, 1 random grants, 2 grants held low
# F : wait for the instruction queue to fill, D : wait for all done
W 0 1f1e1d1c1b1a191817161514131211100f0e0d0c0b0a09080706050403020100
W 1 3f3e3d3c3b3a393837363534333231302f2e2d2c2b2a29282726252423222120
W 2 5f5e5d5c5b5a595857565554535251504f4e4d4c4b4a49484746454443424140
W 3 7f7e7d7c7b7a797877767574737271706f6e6d6c6b6a69686766656463626160
G 0
I 0 0 100 5 1
I 0 1 40 3 2
I 0 2 30 9 3
I 0 3 16 5 4
I 1 0 90 7 5
I 1 1 50 11 6
I 1 2 20 3 7
I 1 3 9 6 8
D
W 0 e0e1e2e3e4e5e6e7e8e9eaebecedeeeff0f1f2f3f4f5f6f7f8f9fafbfcfdfeff
W 1 c0c1c2c3c4c5c6c7c8c9cacbcccdcecfd0d1d2d3d4d5d6d7d8d9dadbdcdddedf
W 2 a0a1a2a3a4a5a6a7a8a9aaabacadaeafb0b1b2b3b4b5b6b7b8b9babbbcbdbebf
W 3 808182838485868788898a8b8c8d8e8f909192939495969798999a9b9c9d9e9f
G 1
I 0 0 64 33 9
I 1 0 60 45 10
I 0 1 30 2 11
I 1 3 4 3 12
D
G 2
I 0 2 32 1 13
I 1 1 20 17 14
I 0 0 50 31 15
I 1 2 16 5 16
F
G 1
D
